//--- list.f
hw/xpose_pkg.sv
hw/row_if.sv
hw/row_collector.sv
hw/transpose_buf.sv
hw/column_reader.sv
hw/xpose_top.sv
tb/xpose_asserts.sv
tb/tb_xpose.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_xpose -f list.f -o sim_xpose

# the simulation may stop with a failure status, the log decides
./obj_dir/sim_xpose > sim.log 2>&1 || true
cat sim.log

if grep -q "^Everything OK$" sim.log; then
    exit 0
else
    exit 1
fi

//--- tb/tb_xpose.sv
module tb_xpose;

    localparam int QW       = 15;
    localparam int NBLK     = 4;
    localparam int MAX_GAP  = 3;
    // blocks that pass through the buffer over the whole run
    localparam int N_BLOCKS = 2 * NBLK;
    // each block is 32 writes and 32 reads, plus stalls of the other side
    localparam longint LIMIT = longint'(N_BLOCKS) * 64 * (MAX_GAP + 8) * 8 * 2 + 2000;

    logic             clk;
    logic             resetn;
    logic             wbw_cyc_i;
    logic             wbw_stb_i;
    logic             wbw_we_i;
    logic [31:0]      wbw_dat_i;
    logic             wbw_ack_o;
    logic             wbr_cyc_i;
    logic             wbr_stb_i;
    logic             wbr_we_i;
    logic [31:0]      wbr_dat_o;
    logic             wbr_ack_o;

    // stimulus table, coefficient index is row*8 + column
    int               tbl_blk [NBLK];
    logic [15:0]      tbl_coef [NBLK][64];
    int               tbl_gap [NBLK];

    time              wr_done_t;
    time              first_ack_t;

    xpose_top #(.QW(QW)) uut (.*);

    bind xpose_top xpose_asserts u_asserts (
        .clk       (clk),
        .resetn    (resetn),
        .wbw_cyc_i (wbw_cyc_i),
        .wbw_stb_i (wbw_stb_i),
        .wbw_ack_o (wbw_ack_o),
        .wbr_cyc_i (wbr_cyc_i),
        .wbr_stb_i (wbr_stb_i),
        .wbr_ack_o (wbr_ack_o)
    );

    always #4 clk = ~clk;

    task automatic check_equal(input logic [31:0] exp, input logic [31:0] got, input string msg);
        if (exp !== got) begin
            $display("FAIL %0t: %s expected %h got %h", $time, msg, exp, got);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // a 15-bit coefficient kept from the half, returned sign-extended
    function automatic logic [15:0] sext_half(input logic [15:0] h);
        return {h[14], h[14:0]};
    endfunction

    function automatic logic [31:0] expected_word(input int b, input int c, input int k);
        return {sext_half(tbl_coef[b][(2 * k + 1) * 8 + c]), sext_half(tbl_coef[b][2 * k * 8 + c])};
    endfunction

    // ##################################################
    // bus drivers, called one edge plus one time unit in
    // ##################################################

    task automatic write_port_access(input logic we, input logic [31:0] d);
        wbw_cyc_i = 1'b1;
        wbw_stb_i = 1'b1;
        wbw_we_i  = we;
        wbw_dat_i = d;
        do begin
            @(posedge clk);
            #1;
        end while (wbw_ack_o !== 1'b1);
        // the transfer ends on the edge that samples ack
        @(posedge clk);
        #1;
        wbw_cyc_i = 1'b0;
        wbw_stb_i = 1'b0;
        wbw_we_i  = 1'b0;
    endtask

    task automatic read_port_access(input logic we, output logic [31:0] d);
        wbr_cyc_i = 1'b1;
        wbr_stb_i = 1'b1;
        wbr_we_i  = we;
        do begin
            @(posedge clk);
            #1;
        end while (wbr_ack_o !== 1'b1);
        d = wbr_dat_o;
        @(posedge clk);
        #1;
        wbr_cyc_i = 1'b0;
        wbr_stb_i = 1'b0;
        wbr_we_i  = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic write_block(input int b);
        for (int r = 0; r < 8; r++) begin
            for (int k = 0; k < 4; k++) begin
                write_port_access(1'b1, {tbl_coef[b][r * 8 + 2 * k + 1],
                                         tbl_coef[b][r * 8 + 2 * k]});
                idle_cycles(tbl_gap[b]);
            end
        end
        wr_done_t = $time;
    endtask

    task automatic read_block(input int b, input bit rnd_gap);
        logic [31:0] d;
        for (int c = 0; c < 8; c++) begin
            for (int k = 0; k < 4; k++) begin
                read_port_access(1'b0, d);
                if (c == 0 && k == 0) begin
                    first_ack_t = $time;
                end
                check_equal(expected_word(b, c, k), d,
                            $sformatf("block %0d column %0d pair %0d", tbl_blk[b], c, k));
                if (rnd_gap) begin
                    idle_cycles(int'($urandom_range(MAX_GAP, 0)));
                end else begin
                    idle_cycles(tbl_gap[b]);
                end
            end
        end
    endtask

    // ##################################################
    // watchdog
    // ##################################################

    initial begin
        #(LIMIT);
        $display("Test timed out waiting for a bus acknowledge");
        $display("Something failed");
        $fatal(1);
    end

    // ##################################################
    // main sequence
    // ##################################################

    initial begin
        logic [31:0] d;
        clk       = 1'b0;
        resetn    = 1'b0;
        wbw_cyc_i = 1'b0;
        wbw_stb_i = 1'b0;
        wbw_we_i  = 1'b0;
        wbw_dat_i = '0;
        wbr_cyc_i = 1'b0;
        wbr_stb_i = 1'b0;
        wbr_we_i  = 1'b0;
        void'($urandom(8));

        // ramp, range extremes with bit 15 as junk, then random words
        for (int i = 0; i < 64; i++) begin
            tbl_coef[0][i] = 16'(i * 37 - 1000);
            tbl_coef[1][i] = (i % 2 == 0) ? 16'h4000 : 16'hBFFF;
            tbl_coef[2][i] = 16'($urandom);
            tbl_coef[3][i] = 16'($urandom);
        end
        for (int b = 0; b < NBLK; b++) begin
            tbl_blk[b] = b;
            tbl_gap[b] = (b == 3) ? MAX_GAP : b % 2;
        end

        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;
        idle_cycles(2);

        // a read issued on an empty buffer waits for the whole block
        fork
            write_block(0);
            read_block(0, 1'b0);
        join
        check_equal(32'd1, 32'(first_ack_t > wr_done_t), "first read acked before block full");

        // accesses in the wrong direction are acked and change nothing
        write_port_access(1'b0, 32'hDEADBEEF);
        read_port_access(1'b1, d);
        write_block(1);
        read_block(1, 1'b0);

        // two blocks in flight, one per bank
        write_block(2);
        write_block(3);
        read_block(2, 1'b0);
        read_block(3, 1'b0);

        // writer runs ahead and stalls while the reader dawdles
        fork
            for (int b = 0; b < NBLK; b++) begin
                write_block(b);
            end
            begin
                idle_cycles(40);
                for (int b = 0; b < NBLK; b++) begin
                    read_block(b, 1'b1);
                end
            end
        join

        idle_cycles(4);
        if (uut.u_asserts.fail_cnt == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("%0d bus handshake assertions failed", uut.u_asserts.fail_cnt);
            $display("Something failed");
            $fatal(1);
        end
    end

endmodule

//--- tb/xpose_asserts.sv
module xpose_asserts (
    input logic clk,
    input logic resetn,
    input logic wbw_cyc_i,
    input logic wbw_stb_i,
    input logic wbw_ack_o,
    input logic wbr_cyc_i,
    input logic wbr_stb_i,
    input logic wbr_ack_o
);

    int fail_cnt = 0;

    // ##################################################
    // Wishbone classic handshakes on both ports
    // ##################################################

    wr_ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        wbw_ack_o |=> !wbw_ack_o) else begin
        fail_cnt++;
        $error("write ack longer than one cycle");
    end

    rd_ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        wbr_ack_o |=> !wbr_ack_o) else begin
        fail_cnt++;
        $error("read ack longer than one cycle");
    end

    wr_ack_with_stb: assert property (@(posedge clk) disable iff (!resetn)
        wbw_ack_o |-> (wbw_cyc_i && wbw_stb_i)) else begin
        fail_cnt++;
        $error("write ack without stb and cyc");
    end

    rd_ack_with_stb: assert property (@(posedge clk) disable iff (!resetn)
        wbr_ack_o |-> (wbr_cyc_i && wbr_stb_i)) else begin
        fail_cnt++;
        $error("read ack without stb and cyc");
    end

    // the ack registers clear on the first edge of reset
    no_ack_in_reset: assert property (@(posedge clk)
        !resetn |=> (!wbw_ack_o && !wbr_ack_o)) else begin
        fail_cnt++;
        $error("ack during reset");
    end

endmodule

//--- hw/xpose_top.sv
module xpose_top #(
    parameter int QW = 15
) (
    input  logic             clk,
    input  logic             resetn,

    // write port, rows in
    input  logic             wbw_cyc_i,
    input  logic             wbw_stb_i,
    input  logic             wbw_we_i,
    input  xpose_pkg::word_t wbw_dat_i,
    output logic             wbw_ack_o,

    // read port, columns out
    input  logic             wbr_cyc_i,
    input  logic             wbr_stb_i,
    input  logic             wbr_we_i,
    output xpose_pkg::word_t wbr_dat_o,
    output logic             wbr_ack_o
);

    row_if #(.QW(QW)) row_bus ();
    row_if #(.QW(QW)) col_bus ();

    row_collector #(.QW(QW)) u_row_collector (
        .clk       (clk),
        .resetn    (resetn),
        .wbw_cyc_i (wbw_cyc_i),
        .wbw_stb_i (wbw_stb_i),
        .wbw_we_i  (wbw_we_i),
        .wbw_dat_i (wbw_dat_i),
        .wbw_ack_o (wbw_ack_o),
        .row_o     (row_bus.src)
    );

    transpose_buf #(.QW(QW)) u_transpose_buf (
        .clk    (clk),
        .resetn (resetn),
        .row_i  (row_bus.dst),
        .col_o  (col_bus.src)
    );

    column_reader #(.QW(QW)) u_column_reader (
        .clk       (clk),
        .resetn    (resetn),
        .col_i     (col_bus.dst),
        .wbr_cyc_i (wbr_cyc_i),
        .wbr_stb_i (wbr_stb_i),
        .wbr_we_i  (wbr_we_i),
        .wbr_dat_o (wbr_dat_o),
        .wbr_ack_o (wbr_ack_o)
    );

endmodule

//--- hw/column_reader.sv
module column_reader #(
    parameter int QW = 15
) (
    input  logic             clk,
    input  logic             resetn,
    row_if.dst               col_i,
    input  logic             wbr_cyc_i,
    input  logic             wbr_stb_i,
    input  logic             wbr_we_i,
    output xpose_pkg::word_t wbr_dat_o,
    output logic             wbr_ack_o
);

    logic signed [QW-1:0] col_q [xpose_pkg::BLK];
    logic                 have_col;
    xpose_pkg::pair_t     pair_cnt;
    xpose_pkg::idx_t      lo_idx;
    xpose_pkg::idx_t      hi_idx;
    xpose_pkg::half_t     lo_half;
    xpose_pkg::half_t     hi_half;
    logic                 take;
    logic                 rd_take;
    logic                 last_rd;
    logic                 load;

    // a read waits for a column, a stray write is acknowledged at once
    assign take    = wbr_cyc_i & wbr_stb_i & ~wbr_ack_o & (wbr_we_i | have_col);
    assign rd_take = take & ~wbr_we_i;
    assign last_rd = rd_take & (pair_cnt == 2'd3);

    // the next column can come in on the same edge as the last read of this one
    assign col_i.hold = have_col & ~last_rd;
    assign load       = col_i.valid & ~col_i.hold;

    assign lo_idx  = {pair_cnt, 1'b0};
    assign hi_idx  = {pair_cnt, 1'b1};
    assign lo_half = {{(16 - QW){col_q[lo_idx][QW-1]}}, col_q[lo_idx]};
    assign hi_half = {{(16 - QW){col_q[hi_idx][QW-1]}}, col_q[hi_idx]};

    // ##################################################
    // Wishbone ack and read data
    // ##################################################

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wbr_ack_o <= 1'b0;
        end else begin
            wbr_ack_o <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_take) begin
            wbr_dat_o <= {hi_half, lo_half};
        end
    end

    // ##################################################
    // column register
    // ##################################################

    always_ff @(posedge clk) begin
        if (!resetn) begin
            have_col <= 1'b0;
            pair_cnt <= '0;
        end else begin
            if (rd_take) begin
                pair_cnt <= pair_cnt + 1'b1;
            end
            if (load) begin
                have_col <= 1'b1;
            end else if (last_rd) begin
                have_col <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            for (int i = 0; i < xpose_pkg::BLK; i++) begin
                col_q[i] <= col_i.data[i];
            end
        end
    end

endmodule

//--- hw/transpose_buf.sv
module transpose_buf #(
    parameter int QW = 15
) (
    input  logic clk,
    input  logic resetn,
    row_if.dst   row_i,
    row_if.src   col_o
);

    // storage is indexed as bank, row, column
    logic signed [QW-1:0] mem [2][xpose_pkg::BLK][xpose_pkg::BLK];
    logic                 wr_bank;
    logic                 rd_bank;
    logic [1:0]           full;
    xpose_pkg::idx_t      col_cnt;
    logic                 row_take;
    logic                 col_take;

    // ##################################################
    // write side
    // ##################################################

    // with both banks full the write bank is full too, so rows are held
    assign row_i.hold = full[wr_bank];
    assign row_take   = row_i.valid & ~full[wr_bank];

    always_ff @(posedge clk) begin
        if (row_take) begin
            for (int c = 0; c < xpose_pkg::BLK; c++) begin
                mem[wr_bank][row_i.idx][c] <= row_i.data[c];
            end
        end
    end

    // ##################################################
    // read side
    // ##################################################

    assign col_o.valid = full[rd_bank];
    assign col_o.idx   = col_cnt;
    assign col_take    = col_o.valid & ~col_o.hold;

    // column c takes element c of every row in the read bank
    always_comb begin
        for (int r = 0; r < xpose_pkg::BLK; r++) begin
            col_o.data[r] = mem[rd_bank][r][col_cnt];
        end
    end

    // ##################################################
    // bank control
    // ##################################################

    // write and read banks never coincide while a row and a column both move,
    // since a row only enters a bank that is not full
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
            full    <= 2'b00;
            col_cnt <= '0;
        end else begin
            if (row_take && row_i.idx == 3'd7) begin
                full[wr_bank] <= 1'b1;
                wr_bank       <= ~wr_bank;
            end
            if (col_take) begin
                col_cnt <= col_cnt + 1'b1;
                if (col_cnt == 3'd7) begin
                    full[rd_bank] <= 1'b0;
                    rd_bank       <= ~rd_bank;
                end
            end
        end
    end

endmodule

//--- hw/row_collector.sv
module row_collector #(
    parameter int QW = 15
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             wbw_cyc_i,
    input  logic             wbw_stb_i,
    input  logic             wbw_we_i,
    input  xpose_pkg::word_t wbw_dat_i,
    output logic             wbw_ack_o,
    row_if.src               row_o
);

    logic signed [QW-1:0] row_q [xpose_pkg::BLK];
    xpose_pkg::pair_t     pair_cnt;
    xpose_pkg::idx_t      row_cnt;
    xpose_pkg::idx_t      lo_idx;
    xpose_pkg::idx_t      hi_idx;
    xpose_pkg::half_t     lo_half;
    xpose_pkg::half_t     hi_half;
    logic                 row_valid;
    logic                 take;
    logic                 wr_take;
    logic                 row_done;

    // no new transfer while a finished row is still waiting on the buffer
    assign take     = wbw_cyc_i & wbw_stb_i & ~wbw_ack_o & ~row_valid;
    assign wr_take  = take & wbw_we_i;
    assign row_done = row_valid & ~row_o.hold;

    assign lo_idx  = {pair_cnt, 1'b0};
    assign hi_idx  = {pair_cnt, 1'b1};
    assign lo_half = wbw_dat_i[15:0];
    assign hi_half = wbw_dat_i[31:16];

    // ##################################################
    // Wishbone ack
    // ##################################################

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wbw_ack_o <= 1'b0;
        end else begin
            wbw_ack_o <= take;
        end
    end

    // ##################################################
    // row assembly
    // ##################################################

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pair_cnt  <= '0;
            row_cnt   <= '0;
            row_valid <= 1'b0;
        end else begin
            if (wr_take) begin
                pair_cnt <= pair_cnt + 1'b1;
                if (pair_cnt == 2'd3) begin
                    row_valid <= 1'b1;
                end
            end
            if (row_done) begin
                row_valid <= 1'b0;
                row_cnt   <= row_cnt + 1'b1;
            end
        end
    end

    // only the low QW bits of each half are kept
    always_ff @(posedge clk) begin
        if (wr_take) begin
            row_q[lo_idx] <= lo_half[QW-1:0];
            row_q[hi_idx] <= hi_half[QW-1:0];
        end
    end

    always_comb begin
        for (int i = 0; i < xpose_pkg::BLK; i++) begin
            row_o.data[i] = row_q[i];
        end
    end

    assign row_o.idx   = row_cnt;
    assign row_o.valid = row_valid;

endmodule

//--- hw/row_if.sv
interface row_if #(
    parameter int QW = 15
);

    // one full row or column of the block
    logic signed [QW-1:0] data [xpose_pkg::BLK];
    xpose_pkg::idx_t      idx;
    logic                 valid;
    logic                 hold;

    // the source keeps data and idx stable while hold is high
    modport src (
        output data,
        output idx,
        output valid,
        input  hold
    );

    modport dst (
        input  data,
        input  idx,
        input  valid,
        output hold
    );

endinterface

//--- hw/xpose_pkg.sv
package xpose_pkg;

    // ##################################################
    // block geometry
    // ##################################################

    // edge of the 8x8 transform block
    localparam int BLK = 8;

    // ##################################################
    // bus and index types
    // ##################################################

    // one Wishbone data word, two coefficients side by side
    typedef logic [31:0] word_t;

    // one coefficient as it travels on the bus, sign-extended
    typedef logic [15:0] half_t;

    // row or column index within a block
    typedef logic [2:0] idx_t;

    // coefficient pair index within a row or column
    typedef logic [1:0] pair_t;

endpackage
